// ==== hw/tl_config.svh ====
`ifndef TL_CONFIG_SVH
`define TL_CONFIG_SVH

// Clock cycles per timer tick.
`define TL_TICK_DIV 2

// Width of the phase timer down-counter.
`define TL_CNT_W 5

// ****************************************
// Phase durations, in timer ticks.
// ****************************************

`define TL_T_STARTUP 10
`define TL_T_GREEN 30
`define TL_T_YELLOW 5
`define TL_T_WALK 10

`endif

// ==== hw/tl_phase_pkg.sv ====
`include "tl_config.svh"

package tl_phase_pkg;

    // Controller phases. The normal cycle runs from ns_green to ew_yellow.
    typedef enum logic [2:0] {
        startup_flash = 3'd0,
        ns_green      = 3'd1,
        ns_yellow     = 3'd2,
        ew_green      = 3'd3,
        ew_yellow     = 3'd4,
        ped_walk      = 3'd5,
        emergency_red = 3'd6
    } phase_t;

    // Request from the FSM to the phase timer.
    typedef struct packed {
        logic                 load;      // One-cycle pulse on phase entry.
        logic [`TL_CNT_W-1:0] duration;  // Phase length in ticks.
    } timer_req_t;

endpackage

// ==== hw/tl_lamp_pkg.sv ====
package tl_lamp_pkg;

    // Lamp code for one road, as produced by the FSM.
    typedef enum logic [1:0] {
        flash  = 2'b00,
        green  = 2'b01,
        yellow = 2'b10,
        red    = 2'b11
    } lamp_code_t;

    // ****************************************
    // Lamp lines on the street
    // ****************************************

    // One bit per lamp head of a road.
    typedef struct packed {
        logic red;
        logic yellow;
        logic green;
    } lamp_lines_t;

endpackage

// ==== hw/tl_phase_fsm.sv ====
`include "tl_config.svh"

module tl_phase_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     emergency,
    input  logic                     ped_pending,
    input  logic                     count_done,
    output tl_phase_pkg::timer_req_t timer_req,
    output logic                     ped_served,
    output tl_phase_pkg::phase_t     phase,
    output tl_lamp_pkg::lamp_code_t  ns_code,
    output tl_lamp_pkg::lamp_code_t  ew_code,
    output logic                     walk,
    output logic                     emergency_active
);
    import tl_phase_pkg::*;
    import tl_lamp_pkg::*;

    phase_t               state;
    phase_t               state_next;
    logic                 entry_q;    // High in the first cycle of every phase.
    logic [`TL_CNT_W-1:0] duration;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= startup_flash;
            entry_q <= 1'b1;
        end else begin
            state   <= state_next;
            entry_q <= (state_next != state);
        end
    end

    // ****************************************
    // Next phase
    // ****************************************

    // Emergency wins over every phase and holds the FSM in all red.
    always_comb begin
        state_next = state;
        if (emergency) begin
            state_next = emergency_red;
        end else begin
            case (state)
                startup_flash: if (count_done) state_next = ns_green;
                ns_green:      if (count_done) state_next = ns_yellow;
                ns_yellow:     if (count_done) state_next = ew_green;
                ew_green:      if (count_done) state_next = ew_yellow;
                ew_yellow: begin
                    if (count_done) begin
                        state_next = ped_pending ? ped_walk : ns_green;
                    end
                end
                ped_walk:      if (count_done) state_next = ns_green;
                default:       state_next = startup_flash;  // Release goes back to flashing.
            endcase
        end
    end

    // ****************************************
    // Lamp codes and phase length
    // ****************************************

    always_comb begin
        ns_code  = red;
        ew_code  = red;
        duration = '0;
        case (state)
            startup_flash: begin
                ns_code  = flash;
                ew_code  = flash;
                duration = `TL_CNT_W'(`TL_T_STARTUP);
            end
            ns_green: begin
                ns_code  = green;
                duration = `TL_CNT_W'(`TL_T_GREEN);
            end
            ns_yellow: begin
                ns_code  = yellow;
                duration = `TL_CNT_W'(`TL_T_YELLOW);
            end
            ew_green: begin
                ew_code  = green;
                duration = `TL_CNT_W'(`TL_T_GREEN);
            end
            ew_yellow: begin
                ew_code  = yellow;
                duration = `TL_CNT_W'(`TL_T_YELLOW);
            end
            ped_walk: duration = `TL_CNT_W'(`TL_T_WALK);
            default: duration = '0;  // All red has no timeout.
        endcase
    end

    // The all-red phase is untimed, so it never loads the timer.
    assign timer_req = '{load: entry_q && (state != emergency_red), duration: duration};

    assign ped_served       = entry_q && (state == ped_walk);
    assign phase            = state;
    assign walk             = (state == ped_walk);
    assign emergency_active = (state == emergency_red);

endmodule

// ==== hw/tl_phase_timer.sv ====
`include "tl_config.svh"

module tl_phase_timer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  tl_phase_pkg::timer_req_t timer_req,
    output logic                     tick,
    output logic                     count_done
);
    localparam int PRE_W = $clog2(`TL_TICK_DIV + 1);

    logic [PRE_W-1:0]     pre_q;
    logic [`TL_CNT_W-1:0] count_q;

    // ****************************************
    // Tick prescaler
    // ****************************************

    assign tick = (pre_q == PRE_W'(`TL_TICK_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_q <= '0;
        end else if (timer_req.load || tick) begin
            pre_q <= '0;  // A load realigns the tick to the phase start.
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

    // ****************************************
    // Phase down-counter
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (timer_req.load) begin
            count_q <= timer_req.duration;
        end else if (tick && (count_q != '0)) begin
            count_q <= count_q - 1'b1;
        end
    end

    // The last tick of a run ends the phase. A run cut short by a new load
    // must not leak a pulse into the phase that just started.
    assign count_done = tick && (count_q == `TL_CNT_W'(1)) && !timer_req.load;

endmodule

// ==== hw/tl_input_cond.sv ====
module tl_input_cond (
    input  logic clk,
    input  logic rst_n,
    input  logic emergency_in,
    input  logic ped_button,
    input  logic ped_served,
    output logic emergency,
    output logic ped_pending
);
    // First synchronizer stage, bit 0 for emergency and bit 1 for the button.
    logic [1:0] meta_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_q <= '0;
        end else begin
            meta_q <= {ped_button, emergency_in};
        end
    end

    // ****************************************
    // Second stage
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            emergency <= 1'b0;
        end else begin
            emergency <= meta_q[0];
        end
    end

    // The request latch doubles as the second stage of the button path.
    // A press seen in the serving cycle sets it again and waits for the
    // next walk phase.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ped_pending <= 1'b0;
        end else begin
            ped_pending <= meta_q[1] | (ped_pending & ~ped_served);
        end
    end

endmodule

// ==== hw/tl_lamp_driver.sv ====
module tl_lamp_driver (
    input  logic                     clk,
    input  logic                     rst_n,
    input  tl_phase_pkg::phase_t     phase,
    input  tl_lamp_pkg::lamp_code_t  ns_code,
    input  tl_lamp_pkg::lamp_code_t  ew_code,
    input  logic                     tick,
    output tl_lamp_pkg::lamp_lines_t ns_lamps,
    output tl_lamp_pkg::lamp_lines_t ew_lamps
);
    import tl_phase_pkg::*;
    import tl_lamp_pkg::*;

    logic blink_q;  // Yellow state while flashing.

    // Exactly one line is lit per code, except the dark half of a blink.
    function automatic lamp_lines_t decode(input lamp_code_t code, input logic blink);
        lamp_lines_t lines;
        lines = '0;
        case (code)
            flash:   lines.yellow = blink;
            green:   lines.green  = 1'b1;
            yellow:  lines.yellow = 1'b1;
            default: lines.red    = 1'b1;
        endcase
        return lines;
    endfunction

    // ****************************************
    // Startup blink
    // ****************************************

    // The blink starts dark each time the startup phase is entered.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blink_q <= 1'b0;
        end else if (phase != startup_flash) begin
            blink_q <= 1'b0;
        end else if (tick) begin
            blink_q <= ~blink_q;
        end
    end

    assign ns_lamps = decode(ns_code, blink_q);
    assign ew_lamps = decode(ew_code, blink_q);

endmodule

// ==== hw/tl_intersection.sv ====
module tl_intersection (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     emergency_in,
    input  logic                     ped_button,
    output tl_lamp_pkg::lamp_lines_t ns_lamps,
    output tl_lamp_pkg::lamp_lines_t ew_lamps,
    output logic                     walk,
    output logic                     emergency_active
);
    import tl_phase_pkg::*;
    import tl_lamp_pkg::*;

    timer_req_t timer_req;
    phase_t     phase;
    lamp_code_t ns_code;
    lamp_code_t ew_code;
    logic       tick;
    logic       count_done;
    logic       emergency;
    logic       ped_pending;
    logic       ped_served;

    tl_input_cond u_cond (
        .clk          (clk),
        .rst_n        (rst_n),
        .emergency_in (emergency_in),
        .ped_button   (ped_button),
        .ped_served   (ped_served),
        .emergency    (emergency),
        .ped_pending  (ped_pending)
    );

    tl_phase_fsm u_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .emergency        (emergency),
        .ped_pending      (ped_pending),
        .count_done       (count_done),
        .timer_req        (timer_req),
        .ped_served       (ped_served),
        .phase            (phase),
        .ns_code          (ns_code),
        .ew_code          (ew_code),
        .walk             (walk),
        .emergency_active (emergency_active)
    );

    tl_phase_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .timer_req  (timer_req),
        .tick       (tick),
        .count_done (count_done)
    );

    // The timer tick also paces the startup blink.
    tl_lamp_driver u_lamps (
        .clk      (clk),
        .rst_n    (rst_n),
        .phase    (phase),
        .ns_code  (ns_code),
        .ew_code  (ew_code),
        .tick     (tick),
        .ns_lamps (ns_lamps),
        .ew_lamps (ew_lamps)
    );

endmodule

// ==== verif/tl_intersection_chk.sv ====
module tl_intersection_chk (
    input logic                     clk,
    input logic                     rst_n,
    input tl_lamp_pkg::lamp_lines_t ns_lamps,
    input tl_lamp_pkg::lamp_lines_t ew_lamps,
    input logic                     walk,
    input logic                     emergency_active
);
    logic both_red;
    int   fail_count = 0;

    assign both_red = ns_lamps.red && ew_lamps.red;

    ns_one_lamp: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ns_lamps))
        else begin
            fail_count++;
            $error("North-south road lights more than one lamp line");
        end

    ew_one_lamp: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ew_lamps))
        else begin
            fail_count++;
            $error("East-west road lights more than one lamp line");
        end

    // Crossing greens would send both roads into the junction.
    no_double_green: assert property (@(posedge clk) disable iff (!rst_n)
        !(ns_lamps.green && ew_lamps.green))
        else begin
            fail_count++;
            $error("Both roads show green");
        end

    walk_all_red: assert property (@(posedge clk) disable iff (!rst_n) walk |-> both_red)
        else begin
            fail_count++;
            $error("Walk shown while a road is not red");
        end

    emergency_all_red: assert property (@(posedge clk) disable iff (!rst_n)
        emergency_active |-> both_red)
        else begin
            fail_count++;
            $error("Emergency active while a road is not red");
        end

endmodule

bind tl_intersection tl_intersection_chk u_chk (
    .clk              (clk),
    .rst_n            (rst_n),
    .ns_lamps         (ns_lamps),
    .ew_lamps         (ew_lamps),
    .walk             (walk),
    .emergency_active (emergency_active)
);

// ==== verif/tl_intersection_tb.sv ====
`include "tl_config.svh"

module tl_intersection_tb;
    import tl_lamp_pkg::*;

    localparam int n_rows     = 6;
    localparam int max_seq    = 12;
    localparam int rand_press = -2;  // Press at a random cycle inside the first ns green.

    logic        clk;
    logic        rst_n;
    logic        emergency_in;
    logic        ped_button;
    lamp_lines_t ns_lamps;
    lamp_lines_t ew_lamps;
    logic        walk;
    logic        emergency_active;

    // ****************************************
    // Scenario table
    // ****************************************

    // Phase letters are S startup, G and Y ns green and yellow, g and y ew green
    // and yellow, W walk, X all red for an emergency. Cycles count from reset
    // release, and -1 leaves an input idle.
    int    press_a [n_rows] = '{-1, rand_press, 40, -1, -1, 40};
    int    press_b [n_rows] = '{-1, -1, 175, -1, -1, -1};
    int    em_on   [n_rows] = '{-1, -1, -1, 100, 5, 170};
    int    em_off  [n_rows] = '{-1, -1, -1, 160, 30, 200};
    string exp_seq [n_rows] = '{"SGYgyG", "SGYgyWGYgyG", "SGYgyWGYgyWG",
                                "SGYgXSGYgyG", "SXSGYgyG", "SGYgyWXSGYgy"};

    int   seed = 32'hacec;
    int   errors;
    int   blink_errors;
    int   rows_failed;
    int   cyc;                 // Cycle number since reset release.
    int   rec_n;
    byte  rec_phase [max_seq];
    int   rec_start [max_seq];
    byte  last_phase;
    logic monitor_on;
    logic blink_ref;

    tl_intersection DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .emergency_in     (emergency_in),
        .ped_button       (ped_button),
        .ns_lamps         (ns_lamps),
        .ew_lamps         (ew_lamps),
        .walk             (walk),
        .emergency_active (emergency_active)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // A timed phase lasts its tick count times the prescaler, plus the entry cycle.
    function automatic int phase_cycles(input byte p);
        case (p)
            "S":      return `TL_T_STARTUP * `TL_TICK_DIV + 1;
            "G", "g": return `TL_T_GREEN * `TL_TICK_DIV + 1;
            "Y", "y": return `TL_T_YELLOW * `TL_TICK_DIV + 1;
            "W":      return `TL_T_WALK * `TL_TICK_DIV + 1;
            default:  return 0;
        endcase
    endfunction

    function automatic int row_cycles(input int r);
        int total;
        int i;
        total = 3;
        for (i = 0; i < exp_seq[r].len(); i++) begin
            total += phase_cycles(exp_seq[r][i]);
        end
        if (em_on[r] >= 0) begin
            total += em_off[r] - em_on[r];
        end
        return total;
    endfunction

    function automatic byte decode_phase(input lamp_lines_t ns, input lamp_lines_t ew,
                                         input logic w, input logic em);
        if (ns.green && ew.red) return "G";
        if (ns.yellow && ew.red) return "Y";
        if (ew.green && ns.red) return "g";
        if (ew.yellow && ns.red) return "y";
        if (ns.red && ew.red) return w ? "W" : (em ? "X" : "?");
        if (ns == ew && !ns.red && !ns.green) return "S";  // Yellow lit or dark.
        return "?";
    endfunction

    // ****************************************
    // Phase monitor
    // ****************************************

    always @(negedge clk) begin : monitor
        byte  now;
        int   j;
        logic expect_y;
        if (!monitor_on) begin
            rec_n      = 0;
            last_phase = "-";
        end else begin
            now = decode_phase(ns_lamps, ew_lamps, walk, emergency_active);
            if (now != last_phase && rec_n < max_seq) begin
                rec_phase[rec_n] = now;
                rec_start[rec_n] = cyc;
                rec_n            = rec_n + 1;
            end
            last_phase = now;
            // Yellow toggles every second cycle once the first tick is counted.
            // Only the startup after reset has a known starting level.
            if (now == "S") begin
                j = cyc - rec_start[rec_n - 1];
                if (j == 1) blink_ref = (rec_n == 1) ? 1'b0 : ns_lamps.yellow;
                expect_y = (j == 0) ? 1'b0 : (blink_ref ^ (((j - 1) / 2) % 2 == 1));
                assert (ns_lamps.yellow == expect_y) else begin
                    blink_errors++;
                    $display("FAILED at %0t: ns_lamps.yellow = %b, expected %b",
                             $time, ns_lamps.yellow, expect_y);
                end
            end
        end
    end

    task automatic run_row(input int r);
        int press_1;
        int len;
        @(posedge clk);
        rst_n        <= 1'b0;
        ped_button   <= 1'b0;
        emergency_in <= 1'b0;
        repeat (2) @(posedge clk);
        len     = exp_seq[r].len();
        press_1 = press_a[r];
        if (press_1 == rand_press) begin
            press_1 = 25 + int'($unsigned($random(seed)) % 50);  // Ns green is 21 to 81.
        end
        cyc        = 0;
        monitor_on = 1'b1;
        rst_n      <= 1'b1;
        do begin
            ped_button   <= (cyc == press_1) || (cyc == press_b[r]);
            emergency_in <= (cyc >= em_on[r]) && (cyc < em_off[r]);
            @(posedge clk);
            cyc = cyc + 1;
        end while (rec_n < len);
        monitor_on = 1'b0;
    endtask

    task automatic check_length(input int i, input int expected);
        int got;
        got = rec_start[i + 1] - rec_start[i];
        assert (got == expected) else begin
            errors++;
            $display("FAILED at %0t: length of phase[%0d] %c = %0d, expected %0d",
                     $time, i, rec_phase[i], got, expected);
        end
    endtask

    task automatic check_row(input int r);
        int i;
        int len;
        len = exp_seq[r].len();
        for (i = 0; i < rec_n && i < len; i++) begin
            assert (rec_phase[i] == exp_seq[r][i]) else begin
                errors++;
                $display("FAILED at %0t: phase[%0d] = %c, expected %c",
                         $time, i, rec_phase[i], exp_seq[r][i]);
            end
        end
        // A phase cut short by an emergency has no fixed length.
        for (i = 0; i + 1 < rec_n; i++) begin
            if (rec_phase[i] == "X") begin
                assert (rec_start[i] == em_on[r] + 3) else begin
                    errors++;
                    $display("FAILED at %0t: all red start = %0d, expected %0d",
                             $time, rec_start[i], em_on[r] + 3);
                end
                check_length(i, em_off[r] - em_on[r]);
            end else if (rec_phase[i + 1] != "X") begin
                check_length(i, phase_cycles(rec_phase[i]));
            end
        end
    endtask

    initial begin : main
        int r;
        int errs_before;
        int errs_row;
        rst_n        = 1'b0;
        emergency_in = 1'b0;
        ped_button   = 1'b0;
        monitor_on   = 1'b0;
        blink_ref    = 1'b0;
        errors       = 0;
        blink_errors = 0;
        rows_failed  = 0;
        for (r = 0; r < n_rows; r++) begin
            errs_before = errors + blink_errors + DUT.u_chk.fail_count;
            run_row(r);
            check_row(r);
            errs_row = errors + blink_errors + DUT.u_chk.fail_count - errs_before;
            if (errs_row != 0) rows_failed++;
            $display("Row %0d %s: %0d phases seen, %0d failures",
                     r, exp_seq[r], rec_n, errs_row);
        end
        $display("Rows run %0d, rows failed %0d, mismatches %0d, assertion failures %0d",
                 n_rows, rows_failed, errors + blink_errors, DUT.u_chk.fail_count);
        if (errors + blink_errors + DUT.u_chk.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        int r;
        int count;
        count = 0;
        @(posedge clk);
        limit = 100;
        for (r = 0; r < n_rows; r++) begin
            limit += row_cycles(r);
        end
        while (count <= limit) begin
            @(posedge clk);
            count++;
        end
        $display("Timeout after %0d cycles, the expected phases never appeared", count);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== tl_intersection.f ====
+incdir+hw
hw/tl_phase_pkg.sv
hw/tl_lamp_pkg.sv
hw/tl_phase_fsm.sv
hw/tl_phase_timer.sv
hw/tl_input_cond.sv
hw/tl_lamp_driver.sv
hw/tl_intersection.sv
verif/tl_intersection_chk.sv
verif/tl_intersection_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tl_intersection_tb
FILELIST  := tl_intersection.f

SOURCES := $(filter %.sv,$(shell cat $(FILELIST))) hw/tl_config.svh
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
